// File: dv/pma_tb_model.svh
// Reference rules of the PMA unit, included inside the testbench module after its imports
`ifndef PMA_TB_MODEL_SVH
`define PMA_TB_MODEL_SVH

  // Reset map: RAM below region 8 and I/O above, ROM in the lower half of region 0
  function automatic pma_reg_t reset_region(int idx);
    pma_reg_t r;
    r.pma_cfg_1 = (idx < PMA_NUM_REGIONS / 2) ? PMA_CFG_RAM : PMA_CFG_IO;
    r.pma_cfg_0 = (idx == 0) ? PMA_CFG_ROM : r.pma_cfg_1;
    return r;
  endfunction

  function automatic pma_cfg_t legalize_half(pma_cfg_t cfg);
    pma_cfg_t fixed;
    fixed = cfg;
    if (cfg.Rsrv == rsrv_reserved) fixed.Rsrv = rsrv_none;          // WARL to none
    if (cfg.AccWidth == acc_width_reserved) fixed.AccWidth = acc_word;  // WARL to word
    return fixed;
  endfunction

  function automatic pma_reg_t legalize_word(word_t w);
    pma_reg_t r;
    r = pma_reg_t'(w);
    r.pma_cfg_1 = legalize_half(r.pma_cfg_1);
    r.pma_cfg_0 = legalize_half(r.pma_cfg_0);
    return r;
  endfunction

  function automatic pma_cfg_t slice_cfg(pma_reg_t r, logic upper);
    return upper ? r.pma_cfg_1 : r.pma_cfg_0;  // Address bit 27
  endfunction

  function automatic logic access_denied(logic perm, acc_width_e width, acc_width_e limit);
    return !perm || (int'(width) > int'(limit));
  endfunction

  // Load first, then store, then fetch
  function automatic pma_fault_t predict_fault(access_req_t acc, pma_cfg_t d_cfg,
                                               pma_cfg_t i_cfg);
    pma_fault_t f;
    logic       ld_bad;
    logic       st_bad;
    logic       fe_bad;
    ld_bad = acc.ren && access_denied(d_cfg.R, acc.d_width, d_cfg.AccWidth);
    st_bad = acc.wen && access_denied(d_cfg.W, acc.d_width, d_cfg.AccWidth);
    fe_bad = acc.xen && access_denied(i_cfg.X, acc.i_width, i_cfg.AccWidth);
    f = '0;
    if (ld_bad) f.load = 1'b1;
    else if (st_bad) f.store = 1'b1;
    else if (fe_bad) f.fetch = 1'b1;
    return f;
  endfunction

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

`endif

// File: dv/pma_unit_tb.sv
// Self-checking testbench of the PMA unit, run as the simulation top with the project file list
`timescale 1ns/1ps
`default_nettype none

module pma_unit_tb;

  import pma_csr_pkg::*;
  import pma_types_pkg::*;

  localparam int         PERIOD   = 40;
  localparam int         DRV_DLY  = 2;
  localparam logic [7:0] CSR_BASE = 8'hBC;

  localparam int N_MAP_CHECKS = 4 * 2 * 4 * 3;  // Regions x halves x widths x kinds
  localparam int N_WRITES     = 24;
  localparam int N_DECODE     = 16;
  localparam int N_RANDOM     = 16;
  localparam int TOTAL_CYCLES = 4 + 16 + N_MAP_CHECKS + 4 + 2 * N_WRITES + N_DECODE + 16 +
                                2 * 8 + 5 * N_RANDOM + 2 * 7;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 50) * PERIOD;

  logic        CLK;
  logic        nRST;
  csr_req_t    csr_req;
  csr_rsp_t    csr_rsp;
  access_req_t acc_req;
  pma_fault_t  fault;

  pma_reg_t    shadow [PMA_NUM_REGIONS];  // Expected register contents
  logic        exp_ack;
  word_t       exp_rdata;
  pma_cfg_t    exp_d_cfg;
  pma_cfg_t    exp_i_cfg;
  pma_fault_t  exp_fault;

  logic [31:0] lfsr_state = 32'd2;
  string       test_name = "";
  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  `include "pma_tb_model.svh"

  pma_unit #(
    .PMA_CSR_BASE (CSR_BASE)
  ) dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .csr_req_i (csr_req),
    .csr_rsp_o (csr_rsp),
    .access_i  (acc_req),
    .fault_o   (fault)
  );

  initial CLK = 1'b0;
  always #(PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < PMA_NUM_REGIONS; i++) shadow[i] <= reset_region(i);
    end else if (exp_ack && csr_req.active) begin
      shadow[csr_req.addr[3:0]] <= legalize_word(csr_req.wdata);
    end
  end

  assign exp_ack   = (csr_req.addr[11:4] == CSR_BASE);
  assign exp_rdata = word_t'(shadow[csr_req.addr[3:0]]);
  assign exp_d_cfg = slice_cfg(shadow[acc_req.daddr[31:28]], acc_req.daddr[27]);
  assign exp_i_cfg = slice_cfg(shadow[acc_req.iaddr[31:28]], acc_req.iaddr[27]);
  assign exp_fault = predict_fault(acc_req, exp_d_cfg, exp_i_cfg);

  a_ack: assert property (@(posedge CLK) disable iff (!nRST) csr_rsp.ack == exp_ack)
    else begin
      errors++;
      $display("mismatch %s: ack expected %0b actual %0b", test_name, $sampled(exp_ack),
               $sampled(csr_rsp.ack));
    end

  a_rdata: assert property (@(posedge CLK) disable iff (!nRST)
                            exp_ack |-> csr_rsp.rdata == exp_rdata)
    else begin
      errors++;
      $display("mismatch %s: rdata expected %h actual %h", test_name, $sampled(exp_rdata),
               $sampled(csr_rsp.rdata));
    end

  a_fault: assert property (@(posedge CLK) disable iff (!nRST) fault == exp_fault)
    else begin
      errors++;
      $display("mismatch %s: fault expected %b actual %b", test_name, $sampled(exp_fault),
               $sampled(fault));
    end

  a_onehot: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(fault))
    else begin
      errors++;
      $display("%s: more than one fault raised at once (%b)", test_name, $sampled(fault));
    end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run stalled", TIMEOUT_NS);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
    end
    return v;
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #DRV_DLY;
  endtask

  task automatic csr_write(csr_addr_t addr, word_t data);
    next_cycle();
    csr_req.addr   = addr;
    csr_req.wdata  = data;
    csr_req.active = 1'b1;
  endtask

  task automatic csr_read(region_idx_t idx);
    next_cycle();
    csr_req.addr   = {CSR_BASE, idx};
    csr_req.wdata  = '0;
    csr_req.active = 1'b0;
  endtask

  // en holds {ren, wen, xen}
  task automatic drive_access(word_t daddr, word_t iaddr, logic [2:0] en, acc_width_e dw,
                              acc_width_e iw);
    next_cycle();
    csr_req.active  = 1'b0;
    acc_req.daddr   = daddr;
    acc_req.iaddr   = iaddr;
    {acc_req.ren, acc_req.wen, acc_req.xen} = en;
    acc_req.d_width = dw;
    acc_req.i_width = iw;
  endtask

  task automatic start_test(string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    int n;
    next_cycle();  // Last stimulus gets sampled here
    csr_req = '0;
    acc_req = '0;
    n = errors - errors_at_start;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", test_name, n);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  task automatic run_reset_map();
    start_test("reset_map");
    for (int i = 0; i < PMA_NUM_REGIONS; i++) csr_read(region_idx_t'(i));
    finish_test();
  endtask

  task automatic run_map_faults();
    int    regions [4];
    word_t rnd;
    word_t addr;
    regions = '{0, 5, 8, 15};  // ROM/RAM, RAM, first and last I/O
    start_test("reset_map_faults");
    foreach (regions[r]) begin
      for (int h = 0; h < 2; h++) begin
        for (int w = 0; w < 4; w++) begin
          for (int k = 0; k < 3; k++) begin
            rnd  = take_bits(27);
            addr = {regions[r][3:0], h[0], rnd[26:0]};
            drive_access(addr, addr, 3'b100 >> k, acc_width_e'(w), acc_width_e'(w));
          end
        end
      end
    end
    finish_test();
  endtask

  task automatic run_half_select();
    start_test("half_select");
    drive_access(32'h0000_0000, 32'h0, 3'b010, acc_word, acc_byte);  // ROM slice
    drive_access(32'h0800_0000, 32'h0, 3'b010, acc_word, acc_byte);  // RAM slice
    drive_access(32'h07FF_FFFC, 32'h0, 3'b010, acc_half, acc_byte);
    drive_access(32'h0FFF_FFFC, 32'h0, 3'b110, acc_byte, acc_byte);
    finish_test();
  endtask

  task automatic run_write_legalize();
    logic [31:0] idx;
    pma_reg_t    w;
    start_test("write_legalize");
    for (int n = 0; n < N_WRITES; n++) begin
      idx = take_bits(4);
      w   = pma_reg_t'(take_bits(32));
      if (take_bits(1)) w.pma_cfg_0.Rsrv = rsrv_reserved;
      if (take_bits(1)) w.pma_cfg_1.Rsrv = rsrv_reserved;
      if (take_bits(1)) w.pma_cfg_0.AccWidth = acc_width_reserved;
      if (take_bits(1)) w.pma_cfg_1.AccWidth = acc_width_reserved;
      csr_write({CSR_BASE, idx[3:0]}, word_t'(w));
      csr_read(idx[3:0]);
    end
    finish_test();
  endtask

  task automatic run_address_decode();
    logic [31:0] hi;
    logic [31:0] lo;
    csr_addr_t   addr;
    start_test("address_decode");
    for (int n = 0; n < N_DECODE; n++) begin
      hi = take_bits(8);
      lo = take_bits(4);
      if (hi[7:0] == CSR_BASE) hi = ~hi;
      addr = {hi[7:0], lo[3:0]};
      if (n == 0) addr = {CSR_BASE - 8'd1, 4'hF};  // Just below the window
      if (n == 1) addr = {CSR_BASE + 8'd1, 4'h0};  // Just above it
      csr_write(addr, take_bits(32));
    end
    for (int i = 0; i < PMA_NUM_REGIONS; i++) csr_read(region_idx_t'(i));
    finish_test();
  endtask

  task automatic run_priority();
    pma_cfg_t    cfg;
    logic [31:0] rnd;
    logic [31:0] dw;
    start_test("fault_priority");
    for (int k = 0; k < 8; k++) begin
      cfg          = '0;
      cfg.R        = k[2];
      cfg.W        = k[1];
      cfg.X        = k[0];
      cfg.AccWidth = acc_half;
      cfg.Rsrv     = rsrv_none;
      csr_write({CSR_BASE, 4'h1}, {cfg, cfg});
      rnd = take_bits(28);
      dw  = take_bits(2);
      drive_access({4'h1, rnd[27:0]}, {4'h1, ~rnd[27:0]}, 3'b111, acc_width_e'(dw[1:0]),
                   acc_byte);
    end
    finish_test();
  endtask

  task automatic run_random_traffic();
    logic [31:0] idx;
    logic [31:0] en;
    logic [31:0] dw;
    logic [31:0] iw;
    word_t       da;
    word_t       ia;
    start_test("random_traffic");
    for (int n = 0; n < N_RANDOM; n++) begin
      idx = take_bits(4);
      csr_write({CSR_BASE, idx[3:0]}, take_bits(32));
      for (int a = 0; a < 4; a++) begin
        da = take_bits(32);
        ia = take_bits(32);
        en = take_bits(3);
        dw = take_bits(2);
        iw = take_bits(2);
        drive_access(da, ia, en[2:0], acc_width_e'(dw[1:0]), acc_width_e'(iw[1:0]));
      end
    end
    finish_test();
  endtask

  initial begin
    csr_req = '0;
    acc_req = '0;
    nRST    = 1'b0;
    repeat (4) @(posedge CLK);
    #DRV_DLY;
    nRST = 1'b1;
    run_reset_map();
    run_map_faults();
    run_half_select();  // Needs region 0 still at reset
    run_write_legalize();
    run_address_decode();
    run_priority();
    run_random_traffic();
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+dv
rtl/pma_csr_pkg.sv
rtl/pma_types_pkg.sv
rtl/pma_csr_port.sv
rtl/pma_reg_file.sv
rtl/pma_access_check.sv
rtl/pma_unit.sv
dv/pma_unit_tb.sv

// File: rtl/pma_access_check.sv
// Prioritized PMA fault check of one data access and one fetch against their slice configs
`timescale 1ns/1ps
`default_nettype none

module pma_access_check (
  input  pma_csr_pkg::access_req_t  access_i,
  input  pma_types_pkg::pma_cfg_t   d_cfg_i,
  input  pma_types_pkg::pma_cfg_t   i_cfg_i,
  output pma_csr_pkg::pma_fault_t   fault_o
);

  import pma_csr_pkg::*;
  import pma_types_pkg::*;

  logic load_viol;
  logic store_viol;
  logic fetch_viol;

  // Enabled access lacking permission or wider than the slice allows
  function automatic logic violates(logic en, logic perm, acc_width_e width, pma_cfg_t cfg);
    return en && (!perm || (width > cfg.AccWidth));
  endfunction

  assign load_viol  = violates(access_i.ren, d_cfg_i.R, access_i.d_width, d_cfg_i);
  assign store_viol = violates(access_i.wen, d_cfg_i.W, access_i.d_width, d_cfg_i);
  assign fetch_viol = violates(access_i.xen, i_cfg_i.X, access_i.i_width, i_cfg_i);

  // Load beats store beats fetch
  always_comb begin
    fault_o = '0;
    if (load_viol) begin
      fault_o.load = 1'b1;
    end else if (store_viol) begin
      fault_o.store = 1'b1;
    end else if (fetch_viol) begin
      fault_o.fetch = 1'b1;
    end
  end

  // At most one fault and only with its own enable
  always_comb begin
    assert final ($onehot0(fault_o) &&
                  (!fault_o.load  || access_i.ren) &&
                  (!fault_o.store || access_i.wen) &&
                  (!fault_o.fetch || access_i.xen))
      else $error("pma_access_check: illegal fault vector %b", fault_o);
  end

endmodule

`default_nettype wire

// File: rtl/pma_csr_pkg.sv
// Definitions for the PMA CSR port and access requests, imported by the PMA RTL and its users
`default_nettype none

package pma_csr_pkg;

  typedef logic [11:0] csr_addr_t;  // Full CSR address
  typedef logic [31:0] word_t;      // Data word and byte address

  // Wider access compares greater
  typedef enum logic [1:0] {
    acc_byte           = 2'b00,
    acc_half           = 2'b01,
    acc_word           = 2'b10,
    acc_width_reserved = 2'b11
  } acc_width_e;

  typedef struct packed {
    csr_addr_t addr;    // Upper bits pick the window
    word_t     wdata;   // Raw value before WARL
    logic      active;  // Write strobe
  } csr_req_t;

  typedef struct packed {
    logic  ack;    // Address lies in the PMA window
    word_t rdata;  // Current register content
  } csr_rsp_t;

  // One data access and one fetch per cycle
  typedef struct packed {
    word_t      daddr;
    word_t      iaddr;
    logic       ren;      // Load
    logic       wen;      // Store
    logic       xen;      // Instruction fetch
    acc_width_e d_width;
    acc_width_e i_width;
  } access_req_t;

  typedef struct packed {
    logic load;
    logic store;
    logic fetch;
  } pma_fault_t;

endpackage

`default_nettype wire

// File: rtl/pma_csr_port.sv
// CSR side of the PMA unit that decodes the window, legalizes writes and returns read data
`timescale 1ns/1ps
`default_nettype none

module pma_csr_port #(
  parameter logic [7:0] PMA_CSR_BASE = 8'hBC  // Upper CSR address bits of the window
) (
  input  pma_csr_pkg::csr_req_t       csr_req_i,
  output pma_csr_pkg::csr_rsp_t       csr_rsp_o,
  output logic                        wr_en_o,
  output pma_types_pkg::region_idx_t  csr_idx_o,
  output pma_types_pkg::pma_reg_t     wr_data_o,
  input  pma_types_pkg::pma_reg_t     rd_data_i
);

  import pma_csr_pkg::*;
  import pma_types_pkg::*;

  localparam int IDX_W = $bits(region_idx_t);

  logic     in_window;
  pma_reg_t raw_val;

  // WARL fix-up of one half
  function automatic pma_cfg_t legalize_cfg(pma_cfg_t cfg);
    pma_cfg_t legal;
    legal = cfg;
    if (cfg.Rsrv == rsrv_reserved) begin
      legal.Rsrv = rsrv_none;
    end
    if (cfg.AccWidth == acc_width_reserved) begin
      legal.AccWidth = acc_word;
    end
    return legal;
  endfunction

  assign in_window = (csr_req_i.addr[11:IDX_W] == PMA_CSR_BASE);
  assign raw_val   = pma_reg_t'(csr_req_i.wdata);

  // Index drives both the read mux and the write target
  assign csr_idx_o = csr_req_i.addr[IDX_W-1:0];
  assign wr_en_o   = in_window & csr_req_i.active;

  // Halves are legalized independently
  always_comb begin
    wr_data_o.pma_cfg_1 = legalize_cfg(raw_val.pma_cfg_1);
    wr_data_o.pma_cfg_0 = legalize_cfg(raw_val.pma_cfg_0);
  end

  always_comb begin
    csr_rsp_o.ack   = in_window;         // Reads need no strobe
    csr_rsp_o.rdata = word_t'(rd_data_i);
  end

  // A write is acknowledged and never alters the permission bits
  always_comb begin
    if (wr_en_o) begin
      assert final (csr_rsp_o.ack &&
                    (wr_data_o.pma_cfg_1.R == raw_val.pma_cfg_1.R) &&
                    (wr_data_o.pma_cfg_1.W == raw_val.pma_cfg_1.W) &&
                    (wr_data_o.pma_cfg_1.X == raw_val.pma_cfg_1.X) &&
                    (wr_data_o.pma_cfg_0.R == raw_val.pma_cfg_0.R) &&
                    (wr_data_o.pma_cfg_0.W == raw_val.pma_cfg_0.W) &&
                    (wr_data_o.pma_cfg_0.X == raw_val.pma_cfg_0.X))
        else $error("pma_csr_port: bad write to index %0d", csr_idx_o);
    end
  end

endmodule

`default_nettype wire

// File: rtl/pma_reg_file.sv
// Sixteen PMA registers with reset map, one CSR write port and two region lookup ports
`timescale 1ns/1ps
`default_nettype none

module pma_reg_file (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        wr_en_i,
  input  pma_types_pkg::region_idx_t  csr_idx_i,
  input  pma_types_pkg::pma_reg_t     wr_data_i,
  output pma_types_pkg::pma_reg_t     rd_data_o,
  input  pma_csr_pkg::word_t          daddr_i,
  input  pma_csr_pkg::word_t          iaddr_i,
  output pma_types_pkg::pma_cfg_t     d_cfg_o,
  output pma_types_pkg::pma_cfg_t     i_cfg_o
);

  import pma_csr_pkg::*;
  import pma_types_pkg::*;

  pma_reg_t [PMA_NUM_REGIONS-1:0] pma_regs;
  region_idx_t                    d_idx;
  region_idx_t                    i_idx;

  // Region from the top address bits
  function automatic region_idx_t region_of(word_t addr);
    return addr[31:28];
  endfunction

  function automatic pma_cfg_t pick_half(pma_reg_t reg_val, logic upper);
    pma_cfg_t cfg;
    if (upper) begin
      cfg = reg_val.pma_cfg_1;
    end else begin
      cfg = reg_val.pma_cfg_0;
    end
    return cfg;
  endfunction

  function automatic logic cfg_legal(pma_cfg_t cfg);
    return (cfg.Rsrv != rsrv_reserved) && (cfg.AccWidth != acc_width_reserved);
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
        pma_regs[i] <= pma_reset_reg(region_idx_t'(i));
      end
    end else if (wr_en_i) begin
      pma_regs[csr_idx_i] <= wr_data_i;  // Already legalized
    end
  end

  assign rd_data_o = pma_regs[csr_idx_i];

  // Bit 27 splits each region into two 128 MB slices
  assign d_idx   = region_of(daddr_i);
  assign i_idx   = region_of(iaddr_i);
  assign d_cfg_o = pick_half(pma_regs[d_idx], daddr_i[27]);
  assign i_cfg_o = pick_half(pma_regs[i_idx], iaddr_i[27]);

  // Reset map and every legalized write keep all stored halves free of reserved codes
  for (genvar g = 0; g < PMA_NUM_REGIONS; g++) begin : g_legal_chk
    assert property (@(posedge CLK) disable iff (!nRST)
      cfg_legal(pma_regs[g].pma_cfg_1) && cfg_legal(pma_regs[g].pma_cfg_0))
      else $error("pma_reg_file: region %0d holds a reserved code", g);
  end

endmodule

`default_nettype wire

// File: rtl/pma_types_pkg.sv
// PMA configuration layout, reservability codes and reset memory map used by the PMA RTL
`default_nettype none

package pma_types_pkg;

  localparam int PMA_NUM_REGIONS = 16;

  typedef logic [$clog2(PMA_NUM_REGIONS)-1:0] region_idx_t;  // One 256 MB region

  // LR/SC reservability of a slice
  typedef enum logic [1:0] {
    rsrv_none         = 2'b00,
    rsrv_non_eventual = 2'b01,
    rsrv_eventual     = 2'b10,
    rsrv_reserved     = 2'b11
  } rsrv_e;

  // Configuration of one 128 MB slice
  typedef struct packed {
    logic [1:0]              reserved_hi;  // Bits 15:14
    logic                    W;
    logic                    R;
    pma_csr_pkg::acc_width_e AccWidth;     // Widest legal access
    logic                    X;
    logic                    idempotent;
    logic                    cacheable;
    logic                    coherent;
    logic [1:0]              amo_class;    // Atomic support level
    logic [1:0]              reserved_lo;  // Bits 3:2
    rsrv_e                   Rsrv;
  } pma_cfg_t;

  // Address bit 27 picks the half
  typedef struct packed {
    pma_cfg_t pma_cfg_1;
    pma_cfg_t pma_cfg_0;
  } pma_reg_t;

  localparam pma_cfg_t PMA_CFG_RAM = 16'h3BF1;  // RWX word, cached, LR/SC
  localparam pma_cfg_t PMA_CFG_ROM = 16'h1BF1;  // Same as RAM without W
  localparam pma_cfg_t PMA_CFG_IO  = 16'h3B30;  // Uncached, no reservations

  // Regions 0 to 7 are RAM with a ROM lower half in region 0
  function automatic pma_reg_t pma_reset_reg(region_idx_t idx);
    pma_reg_t reg_val;
    if (idx >= region_idx_t'(PMA_NUM_REGIONS / 2)) begin
      reg_val.pma_cfg_1 = PMA_CFG_IO;
      reg_val.pma_cfg_0 = PMA_CFG_IO;
    end else begin
      reg_val.pma_cfg_1 = PMA_CFG_RAM;
      reg_val.pma_cfg_0 = PMA_CFG_RAM;
    end
    if (idx == '0) begin
      reg_val.pma_cfg_0 = PMA_CFG_ROM;  // Boot ROM slice
    end
    return reg_val;
  endfunction

endpackage

`default_nettype wire

// File: rtl/pma_unit.sv
// PMA unit top level joining CSR port, register file and access checker for the core
`timescale 1ns/1ps
`default_nettype none

module pma_unit #(
  parameter logic [7:0] PMA_CSR_BASE = 8'hBC  // CSR window base
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  pma_csr_pkg::csr_req_t     csr_req_i,
  output pma_csr_pkg::csr_rsp_t     csr_rsp_o,
  input  pma_csr_pkg::access_req_t  access_i,
  output pma_csr_pkg::pma_fault_t   fault_o
);

  import pma_types_pkg::*;

  logic        wr_en;
  region_idx_t csr_idx;   // Shared read and write index
  pma_reg_t    wr_data;
  pma_reg_t    rd_data;
  pma_cfg_t    d_cfg;
  pma_cfg_t    i_cfg;

  pma_csr_port #(
    .PMA_CSR_BASE (PMA_CSR_BASE)
  ) u_csr_port (
    .csr_req_i (csr_req_i),
    .csr_rsp_o (csr_rsp_o),
    .wr_en_o   (wr_en),
    .csr_idx_o (csr_idx),
    .wr_data_o (wr_data),
    .rd_data_i (rd_data)
  );

  pma_reg_file u_reg_file (
    .CLK       (CLK),
    .nRST      (nRST),
    .wr_en_i   (wr_en),
    .csr_idx_i (csr_idx),
    .wr_data_i (wr_data),
    .rd_data_o (rd_data),
    .daddr_i   (access_i.daddr),
    .iaddr_i   (access_i.iaddr),
    .d_cfg_o   (d_cfg),
    .i_cfg_o   (i_cfg)
  );

  pma_access_check u_access_check (
    .access_i (access_i),
    .d_cfg_i  (d_cfg),
    .i_cfg_i  (i_cfg),
    .fault_o  (fault_o)
  );

endmodule

`default_nettype wire
